/* hdl/controlEncoder.sv */
module controlEncoder
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  phase_t       phase,
	input  instrClass_t  cls,
	output dpCtrl_t      dpCtrl,
	output ctrlStrobes_t strobes
);

	//////////////////////////////
	// selects from class only

	always_comb begin
		dpCtrl.regDst   = 1'b0;
		dpCtrl.aluSrc   = 1'b0;
		dpCtrl.memToReg = 1'b0;
		dpCtrl.linkSel  = 1'b0;
		dpCtrl.extOp    = ZERO;
		dpCtrl.aluOp    = ADD;

		// SLT is named in both packages
		case (cls)
			ADDU, SUBU, isaPkg::SLT: dpCtrl.regDst = 1'b1; // write rd
			ORI, ADDIU, LUI, LW, SW: dpCtrl.aluSrc = 1'b1; // imm operand
			default: dpCtrl.regDst = 1'b0;
		endcase

		case (cls)
			ADDIU, LW, SW, BEQ: dpCtrl.extOp = SIGN;
			LUI: dpCtrl.extOp = UPPER;
			default: dpCtrl.extOp = ZERO;
		endcase

		case (cls)
			SUBU, BEQ: dpCtrl.aluOp = SUB; // beq compares by subtraction
			ORI, LUI: dpCtrl.aluOp = OR; // lui ors upper imm into zero
			isaPkg::SLT: dpCtrl.aluOp = ctrlPkg::SLT;
			default: dpCtrl.aluOp = ADD;
		endcase

		dpCtrl.memToReg = (cls == LW);
		dpCtrl.linkSel  = (cls == JAL);
	end

	//////////////////////////////
	// pc source and strobes

	always_comb begin
		dpCtrl.nPcSel = PLUS4;
		strobes       = '0;

		case (phase)
			FETCH: begin
				strobes.irWr  = 1'b1;
				strobes.pcWr  = 1'b1;
				dpCtrl.nPcSel = PLUS4;
			end
			DECODE: begin
				if (cls == JAL) begin
					strobes.pcWr  = 1'b1;
					dpCtrl.nPcSel = JUMP;
				end else if (cls == ERET) begin
					strobes.pcWr   = 1'b1;
					strobes.exlClr = 1'b1;
					dpCtrl.nPcSel  = EPC;
				end
			end
			EXECUTE: begin
				case (cls)
					J: begin
						strobes.pcWr  = 1'b1;
						dpCtrl.nPcSel = JUMP;
					end
					JR: begin
						strobes.pcWr  = 1'b1;
						dpCtrl.nPcSel = REG;
					end
					BEQ: begin
						strobes.pcWr  = 1'b1; // zero flag qualifies in datapath
						dpCtrl.nPcSel = BRANCH;
					end
					default: dpCtrl.nPcSel = PLUS4;
				endcase
			end
			MEMORY: strobes.memWr = (cls == SW);
			WRITEBACK: strobes.regWr = 1'b1;
			INT_ENTRY: begin
				strobes.pcWr   = 1'b1;
				strobes.epcWr  = 1'b1; // save return pc
				strobes.exlSet = 1'b1;
				strobes.cp0We  = 1'b1;
				dpCtrl.nPcSel  = INTVEC;
			end
			default: strobes = '0;
		endcase
	end

	//////////////////////////////
	// checks

	always_comb begin
		assert final (!(strobes.memWr && strobes.regWr))
		else $error("controlEncoder: memWr and regWr both high in %s", phase.name());
	end

endmodule

/* hdl/ctrlConsts.svh */
`ifndef CTRL_CONSTS_SVH
`define CTRL_CONSTS_SVH

//////////////////////////////
// instruction word

`define WORD_W 32 // full instruction
`define OPCODE_W 6 // opcode and funct fields
`define REG_ADDR_W 5 // rs, rt, rd and shamt

//////////////////////////////
// datapath select widths

`define ALU_OP_W 4 // alu operation code
`define EXT_OP_W 2 // immediate extender mode
`define NPC_SEL_W 3 // next pc source

`endif

/* hdl/ctrlPkg.sv */
`include "ctrlConsts.svh"

package ctrlPkg;

	//////////////////////////////
	// sequencer phases

	typedef enum logic [2:0] {
		FETCH     = 3'd0,
		DECODE    = 3'd1,
		EXECUTE   = 3'd2,
		MEMORY    = 3'd3,
		WRITEBACK = 3'd4,
		INT_ENTRY = 3'd5 // epc save and vector
	} phase_t;

	//////////////////////////////
	// datapath selects

	typedef enum logic [`ALU_OP_W-1:0] {
		ADD = 4'b0000,
		SUB = 4'b0001,
		OR  = 4'b0010,
		SLT = 4'b0100
	} aluOp_t;

	typedef enum logic [`EXT_OP_W-1:0] {
		ZERO  = 2'b00,
		SIGN  = 2'b01,
		UPPER = 2'b10 // imm into upper half
	} extOp_t;

	typedef enum logic [`NPC_SEL_W-1:0] {
		PLUS4  = 3'b000,
		BRANCH = 3'b001, // pc+4 plus offset when zero flag set
		JUMP   = 3'b010,
		REG    = 3'b011,
		INTVEC = 3'b100,
		EPC    = 3'b101
	} nPcSel_t;

	typedef struct packed {
		logic    regDst; // rd instead of rt
		logic    aluSrc; // extended imm as operand b
		logic    memToReg;
		logic    linkSel; // pc+4 into r31
		extOp_t  extOp;
		aluOp_t  aluOp;
		nPcSel_t nPcSel;
	} dpCtrl_t;

	typedef struct packed {
		logic irWr;
		logic pcWr;
		logic regWr;
		logic memWr;
		logic cp0We;
		logic epcWr;
		logic exlSet;
		logic exlClr;
	} ctrlStrobes_t;

endpackage

/* hdl/instrDecode.sv */
module instrDecode
	import isaPkg::*;
(
	input  instrFields_t instr,
	output instrClass_t  cls
);

	always_comb begin
		cls = NOP;
		case (instr.opcode)
			OP_SPECIAL: begin
				case (instr.funct)
					FN_ADDU: cls = ADDU;
					FN_SUBU: cls = SUBU;
					FN_SLT:  cls = SLT;
					FN_JR:   cls = JR;
					default: cls = NOP;
				endcase
			end
			OP_ORI:   cls = ORI;
			OP_ADDIU: cls = ADDIU;
			OP_LUI:   cls = LUI;
			OP_LW:    cls = LW;
			OP_SW:    cls = SW;
			OP_BEQ:   cls = BEQ;
			OP_J:     cls = J;
			OP_JAL:   cls = JAL;
			OP_COP0: begin
				// only eret is kept from cop0
				if (instr.rs == RS_ERET) begin
					cls = ERET;
				end else begin
					cls = NOP;
				end
			end
			default: cls = NOP; // unknown word
		endcase
	end

	//////////////////////////////
	// checks

	always_comb begin
		assert final ($isunknown(instr) || !$isunknown(cls))
		else $error("instrDecode: class unknown for known word %h", instr);
	end

endmodule

/* hdl/isaPkg.sv */
`include "ctrlConsts.svh"

package isaPkg;

	//////////////////////////////
	// instruction fields, msb first

	typedef struct packed {
		logic [`OPCODE_W-1:0]   opcode;
		logic [`REG_ADDR_W-1:0] rs;
		logic [`REG_ADDR_W-1:0] rt;
		logic [`REG_ADDR_W-1:0] rd;
		logic [`REG_ADDR_W-1:0] shamt;
		logic [`OPCODE_W-1:0]   funct;
	} instrFields_t;

	// one entry per supported instruction
	typedef enum logic [3:0] {
		ADDU  = 4'd0,
		SUBU  = 4'd1,
		SLT   = 4'd2,
		ORI   = 4'd3,
		ADDIU = 4'd4,
		LUI   = 4'd5,
		LW    = 4'd6,
		SW    = 4'd7,
		BEQ   = 4'd8,
		J     = 4'd9,
		JAL   = 4'd10,
		JR    = 4'd11,
		ERET  = 4'd12,
		NOP   = 4'd13 // also any unknown word
	} instrClass_t;

	//////////////////////////////
	// encodings

	localparam logic [`OPCODE_W-1:0] OP_SPECIAL = 6'b000000; // r-type, split by funct
	localparam logic [`OPCODE_W-1:0] OP_ORI     = 6'b001101;
	localparam logic [`OPCODE_W-1:0] OP_ADDIU   = 6'b001001;
	localparam logic [`OPCODE_W-1:0] OP_LUI     = 6'b001111;
	localparam logic [`OPCODE_W-1:0] OP_LW      = 6'b100011;
	localparam logic [`OPCODE_W-1:0] OP_SW      = 6'b101011;
	localparam logic [`OPCODE_W-1:0] OP_BEQ     = 6'b000100;
	localparam logic [`OPCODE_W-1:0] OP_J       = 6'b000010;
	localparam logic [`OPCODE_W-1:0] OP_JAL     = 6'b000011;
	localparam logic [`OPCODE_W-1:0] OP_COP0    = 6'b010000; // split by rs

	localparam logic [`OPCODE_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [`OPCODE_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [`OPCODE_W-1:0] FN_SLT  = 6'b101010;
	localparam logic [`OPCODE_W-1:0] FN_JR   = 6'b001000;

	localparam logic [`REG_ADDR_W-1:0] RS_ERET = 5'b10000;

endpackage

/* hdl/multiCycleCtrl.sv */
`include "ctrlConsts.svh"

module multiCycleCtrl
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  logic [`WORD_W-1:0] instr,
	input  logic               intReq,
	output dpCtrl_t            dpCtrl,
	output ctrlStrobes_t       strobes
);

	instrClass_t cls;
	phase_t      phase;

	instrDecode decoder (
		.instr(instrFields_t'(instr)),
		.cls  (cls)
	);

	phaseSequencer sequencer (
		.clk   (clk),
		.rst   (rst),
		.cls   (cls),
		.intReq(intReq),
		.phase (phase)
	);

	controlEncoder encoder (
		.phase  (phase),
		.cls    (cls),
		.dpCtrl (dpCtrl),
		.strobes(strobes)
	);

endmodule

/* hdl/phaseSequencer.sv */
module phaseSequencer
	import isaPkg::*;
	import ctrlPkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  instrClass_t cls,
	input  logic        intReq,
	output phase_t      phase
);

	phase_t nextPhase;
	logic   lastPhase; // instruction completes this cycle

	//////////////////////////////
	// end of instruction

	always_comb begin
		case (phase)
			EXECUTE: lastPhase = (cls == BEQ) || (cls == J) || (cls == JR);
			MEMORY: lastPhase = (cls != LW); // sw ends here
			WRITEBACK: lastPhase = 1'b1;
			default: lastPhase = 1'b0;
		endcase
	end

	//////////////////////////////
	// next phase

	always_comb begin
		nextPhase = FETCH;
		if (lastPhase) begin
			if (intReq) begin
				nextPhase = INT_ENTRY; // intReq comes in already masked
			end else begin
				nextPhase = FETCH;
			end
		end else begin
			case (phase)
				FETCH: nextPhase = DECODE;
				DECODE: begin
					case (cls)
						JAL: nextPhase = WRITEBACK; // jump taken in decode
						ERET, NOP: nextPhase = FETCH;
						default: nextPhase = EXECUTE;
					endcase
				end
				EXECUTE: begin
					if ((cls == LW) || (cls == SW)) begin
						nextPhase = MEMORY;
					end else begin
						nextPhase = WRITEBACK; // alu classes
					end
				end
				MEMORY: nextPhase = WRITEBACK; // lw
				default: nextPhase = FETCH; // int entry
			endcase
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			phase <= FETCH;
		end else begin
			phase <= nextPhase;
		end
	end

	//////////////////////////////
	// checks

	assert property (@(posedge clk) disable iff (rst)
		phase == INT_ENTRY |=> phase == FETCH)
	else $error("phaseSequencer: INT_ENTRY not followed by FETCH");

	// class was decided one cycle before memory is entered
	assert property (@(posedge clk) disable iff (rst)
		phase == MEMORY |-> ($past(cls) == LW) || ($past(cls) == SW))
	else $error("phaseSequencer: MEMORY entered for class %s", cls.name());

endmodule

/* run.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --assert --timescale 1ns/100ps --top-module multiCycleCtrlTb \
	-f verilog.f -o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/simv > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$log"; then
	echo "result: pass"
	exit 0
fi
echo "result: fail"
exit 1

/* tb/multiCycleCtrlTb.sv */
`include "ctrlConsts.svh"

module multiCycleCtrlTb
	import isaPkg::*;
	import ctrlPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int nRand     = 200;
	localparam int nIssued   = 27 + nRand; // directed, idle fillers and random
	localparam int maxCycles = 6 * nIssued + 50;

	localparam logic [`WORD_W-1:0] idleWord  = 32'hfc00_0000; // opcode 6'h3f, unknown
	localparam ctrlStrobes_t       fetchOnly = 8'b1100_0000; // irWr and pcWr

	typedef struct packed {
		phase_t       nextPhase;
		dpCtrl_t      dp;
		ctrlStrobes_t st;
	} refOut_t;

	logic               clk = 1'b0;
	logic               rst;
	logic [`WORD_W-1:0] instr;
	logic               intReq;
	dpCtrl_t            dpCtrl;
	ctrlStrobes_t       strobes;

	phase_t      mPhase; // sequencer as the rules give it
	instrClass_t mCls;
	refOut_t     expOut;

	integer seed = 32'hd339_523f;
	int errors = 0;
	int cycleCnt = 0;
	int testNum = 0;
	int failedTests = 0;
	int testStartErrors = 0;

	logic        inReset = 1'b1;
	logic        intTaken = 1'b0;
	int          latCount = 0;
	instrClass_t lastCls = NOP;

	multiCycleCtrl UUT (
		.clk    (clk),
		.rst    (rst),
		.instr  (instr),
		.intReq (intReq),
		.dpCtrl (dpCtrl),
		.strobes(strobes)
	);

	always #10 clk = ~clk;

	//////////////////////////////
	// reference rules

	function automatic instrClass_t classify(logic [`WORD_W-1:0] w);
		instrFields_t f;
		f = w;
		if (f.opcode == OP_SPECIAL && f.funct == FN_ADDU) return ADDU;
		if (f.opcode == OP_SPECIAL && f.funct == FN_SUBU) return SUBU;
		if (f.opcode == OP_SPECIAL && f.funct == FN_SLT) return isaPkg::SLT;
		if (f.opcode == OP_SPECIAL && f.funct == FN_JR) return JR;
		if (f.opcode == OP_COP0 && f.rs == RS_ERET) return ERET;
		if (f.opcode == OP_ORI) return ORI;
		if (f.opcode == OP_ADDIU) return ADDIU;
		if (f.opcode == OP_LUI) return LUI;
		if (f.opcode == OP_LW) return LW;
		if (f.opcode == OP_SW) return SW;
		if (f.opcode == OP_BEQ) return BEQ;
		if (f.opcode == OP_J) return J;
		if (f.opcode == OP_JAL) return JAL;
		return NOP;
	endfunction

	function automatic logic isFinal(phase_t ph, instrClass_t c);
		return (ph == WRITEBACK) || (ph == EXECUTE && c inside {BEQ, J, JR})
			|| (ph == MEMORY && c == SW);
	endfunction

	function automatic int latencyOf(instrClass_t c);
		case (c)
			LW: return 5;
			BEQ, J, JR, JAL: return 3;
			ERET, NOP: return 2;
			default: return 4; // alu classes and sw
		endcase
	endfunction

	function automatic refOut_t refStep(phase_t ph, instrClass_t c, logic irq);
		refOut_t r;
		r = '0;
		r.dp.regDst   = c inside {ADDU, SUBU, isaPkg::SLT};
		r.dp.aluSrc   = c inside {ORI, ADDIU, LUI, LW, SW};
		r.dp.memToReg = (c == LW);
		r.dp.linkSel  = (c == JAL);
		case (c)
			ADDIU, LW, SW, BEQ: r.dp.extOp = SIGN;
			LUI: r.dp.extOp = UPPER;
			default: r.dp.extOp = ZERO;
		endcase
		case (c)
			SUBU, BEQ: r.dp.aluOp = SUB;
			ORI, LUI: r.dp.aluOp = OR;
			isaPkg::SLT: r.dp.aluOp = ctrlPkg::SLT;
			default: r.dp.aluOp = ADD;
		endcase
		r.dp.nPcSel = PLUS4;
		if (ph == FETCH) r.st = fetchOnly;
		if (ph == DECODE && c == JAL) begin
			r.st.pcWr   = 1'b1;
			r.dp.nPcSel = JUMP;
		end
		if (ph == DECODE && c == ERET) begin
			r.st.pcWr   = 1'b1;
			r.st.exlClr = 1'b1;
			r.dp.nPcSel = EPC;
		end
		if (ph == EXECUTE && c inside {J, JR, BEQ}) begin
			r.st.pcWr = 1'b1;
			if (c == J) r.dp.nPcSel = JUMP;
			else if (c == JR) r.dp.nPcSel = REG;
			else r.dp.nPcSel = BRANCH;
		end
		r.st.memWr = (ph == MEMORY) && (c == SW);
		r.st.regWr = (ph == WRITEBACK);
		if (ph == INT_ENTRY) begin
			r.st.pcWr   = 1'b1;
			r.st.epcWr  = 1'b1;
			r.st.exlSet = 1'b1;
			r.st.cp0We  = 1'b1;
			r.dp.nPcSel = INTVEC;
		end
		if (isFinal(ph, c) && irq) r.nextPhase = INT_ENTRY;
		else if (isFinal(ph, c)) r.nextPhase = FETCH;
		else if (ph == FETCH) r.nextPhase = DECODE;
		else if (ph == DECODE && c == JAL) r.nextPhase = WRITEBACK;
		else if (ph == DECODE && c inside {ERET, NOP}) r.nextPhase = FETCH;
		else if (ph == DECODE) r.nextPhase = EXECUTE;
		else if (ph == EXECUTE && c inside {LW, SW}) r.nextPhase = MEMORY;
		else if (ph == EXECUTE || ph == MEMORY) r.nextPhase = WRITEBACK;
		else r.nextPhase = FETCH;
		return r;
	endfunction

	assign mCls   = classify(instr);
	assign expOut = refStep(mPhase, mCls, intReq);

	always @(posedge clk or posedge rst) begin
		if (rst) begin
			mPhase <= FETCH;
		end else begin
			mPhase <= expOut.nextPhase;
		end
	end

	//////////////////////////////
	// compare and timeout

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	always @(negedge clk) begin
		if (rst) begin
			inReset  = 1'b1;
			latCount = 0;
		end else begin
			if (inReset) begin
				check(32'(strobes), 32'(fetchOnly), "strobes in first fetch");
				check(32'(dpCtrl.nPcSel), 32'(PLUS4), "nPcSel in first fetch");
				inReset = 1'b0;
			end
			check(32'(dpCtrl), 32'(expOut.dp), $sformatf("dpCtrl in %s", mPhase.name()));
			check(32'(strobes), 32'(expOut.st), $sformatf("strobes in %s", mPhase.name()));
			if (strobes.irWr) begin // fetch to fetch latency
				if (latCount > 0) begin
					check(latCount, latencyOf(lastCls) + (intTaken ? 1 : 0),
						$sformatf("latency of %s", lastCls.name()));
				end
				latCount = 1;
				intTaken = 1'b0;
			end else begin
				latCount++;
				lastCls = mCls;
				if (mPhase == INT_ENTRY) intTaken = 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		cycleCnt = cycleCnt + 1;
		if (cycleCnt >= maxCycles) begin
			$display("timeout: run did not end within %0d cycles", maxCycles);
			$display("TB FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// stimulus

	function automatic logic [`WORD_W-1:0] encode(logic [5:0] op, logic [4:0] rs, logic [5:0] fn);
		instrFields_t f;
		f.opcode = op;
		f.rs     = rs;
		f.rt     = 5'd8;
		f.rd     = 5'd9;
		f.shamt  = 5'd0;
		f.funct  = fn; // low imm bits for i-type
		return f;
	endfunction

	function automatic logic [`WORD_W-1:0] randomWord();
		instrFields_t f;
		int pick;
		f = $random(seed);
		pick = $random(seed) & 15;
		case (pick)
			0: f = encode(OP_SPECIAL, f.rs, FN_ADDU);
			1: f = encode(OP_SPECIAL, f.rs, FN_SUBU);
			2: f = encode(OP_SPECIAL, f.rs, FN_SLT);
			3: f = encode(OP_SPECIAL, f.rs, FN_JR);
			4: f.opcode = OP_ORI;
			5: f.opcode = OP_ADDIU;
			6: f.opcode = OP_LUI;
			7: f.opcode = OP_LW;
			8: f.opcode = OP_SW;
			9: f.opcode = OP_BEQ;
			10: f.opcode = OP_J;
			11: f.opcode = OP_JAL;
			12: f = encode(OP_COP0, RS_ERET, f.funct);
			13: f.opcode = OP_COP0; // mostly non-eret cop0
			default: f.funct = f.funct; // raw word
		endcase
		return f;
	endfunction

	// mode 0 quiet, 1 intReq always, 2 only outside final phases, 3 random
	task automatic issue(input logic [`WORD_W-1:0] word, input int mode);
		instr = word;
		do begin
			case (mode)
				1: intReq = 1'b1;
				2: intReq = !isFinal(mPhase, classify(word));
				3: intReq = (($random(seed) & 3) == 0);
				default: intReq = 1'b0;
			endcase
			@(posedge clk);
			#2;
		end while (!strobes.irWr);
		intReq = 1'b0;
	endtask

	task automatic report(input string name);
		issue(idleWord, 0); // lets the last latency check land
		testNum++;
		if (errors == testStartErrors) begin
			$display("test %0d %s: ok", testNum, name);
		end else begin
			failedTests++;
			$display("test %0d %s: %0d errors", testNum, name, errors - testStartErrors);
		end
		testStartErrors = errors;
	endtask

	initial begin
		rst    = 1'b1;
		instr  = idleWord;
		intReq = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;

		issue(idleWord, 0);
		report("reset and first fetch");

		issue(encode(OP_SPECIAL, 5'd1, FN_ADDU), 0);
		issue(encode(OP_SPECIAL, 5'd2, FN_SUBU), 0);
		issue(encode(OP_SPECIAL, 5'd3, FN_SLT), 0);
		issue(encode(OP_ORI, 5'd4, 6'h15), 0);
		issue(encode(OP_ADDIU, 5'd5, 6'h2a), 0);
		issue(encode(OP_LUI, 5'd0, 6'h01), 0);
		report("alu classes");

		issue(encode(OP_LW, 5'd6, 6'h04), 0);
		issue(encode(OP_SW, 5'd6, 6'h08), 0);
		report("load and store");

		issue(encode(OP_J, 5'd0, 6'h10), 0);
		issue(encode(OP_SPECIAL, 5'd31, FN_JR), 0);
		issue(encode(OP_BEQ, 5'd1, 6'h03), 0);
		issue(encode(OP_JAL, 5'd0, 6'h20), 0);
		report("jumps and branch");

		issue(encode(OP_SPECIAL, 5'd1, FN_ADDU), 1);
		issue(encode(OP_SW, 5'd2, 6'h0c), 1);
		issue(encode(OP_JAL, 5'd0, 6'h30), 1);
		issue(encode(OP_SPECIAL, 5'd1, FN_SUBU), 2);
		issue(encode(OP_LW, 5'd3, 6'h00), 2);
		report("interrupt entry");

		issue(encode(OP_COP0, RS_ERET, 6'h18), 0);
		issue(encode(OP_SPECIAL, 5'd0, 6'h3f), 0);
		report("eret and unknown word");

		for (int k = 0; k < nRand; k++) begin
			issue(randomWord(), 3);
		end
		report("random stream");

		$display("tests %0d, failed tests %0d, errors %0d", testNum, failedTests, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/instrDecode.sv
hdl/phaseSequencer.sv
hdl/controlEncoder.sv
hdl/multiCycleCtrl.sv
tb/multiCycleCtrlTb.sv
